/* files.f */
hw/sample_buffer_pkg.sv
hw/capture_writer.sv
hw/bank_memory.sv
hw/readout_serializer.sv
hw/sample_buffer.sv
verification/tb_clock.sv
verification/sample_buffer_assert.sv
verification/sample_buffer_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -f files.f \
		--top-module sample_buffer_tb -Mdir obj_dir
	./obj_dir/Vsample_buffer_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "test ended early"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)

/* verification/sample_buffer_tb.sv */
// rows run in order; a row without stop must send enough samples for one channel to fill
`default_nettype none

module sample_buffer_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    sample_buffer_pkg::bank_mode_t mode;
    logic [15:0] cycles;
    logic sparse;
    logic toggle_ready;
    logic use_stop;
  } row_t;

  localparam int row_count = 9;
  localparam int max_words = sample_buffer_pkg::banks * sample_buffer_pkg::bank_depth;

  // mode, sample cycles, sparse valid, toggling ready, stop on the last cycle
  localparam row_t rows [row_count] = '{
    '{sample_buffer_pkg::mode_1ch, 16'd10, 1'b0, 1'b0, 1'b1},
    '{sample_buffer_pkg::mode_2ch, 16'd12, 1'b0, 1'b1, 1'b1},
    '{sample_buffer_pkg::mode_4ch, 16'd9, 1'b0, 1'b0, 1'b1},
    '{sample_buffer_pkg::mode_1ch, 16'd128, 1'b0, 1'b0, 1'b0},
    '{sample_buffer_pkg::mode_2ch, 16'd64, 1'b0, 1'b1, 1'b0},
    '{sample_buffer_pkg::mode_4ch, 16'd32, 1'b0, 1'b0, 1'b0},
    // same mode as before, so a mode strobe taken during readout would show here
    '{sample_buffer_pkg::mode_4ch, 16'd128, 1'b1, 1'b1, 1'b0},
    '{sample_buffer_pkg::mode_2ch, 16'd256, 1'b1, 1'b0, 1'b0},
    '{sample_buffer_pkg::mode_1ch, 16'd20, 1'b1, 1'b1, 1'b1}
  };

  logic clk;
  logic reset;
  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::sample_width-1:0] sample_data;
  logic [sample_buffer_pkg::channels-1:0] sample_valid;
  sample_buffer_pkg::bank_mode_t banking_mode;
  logic config_valid;
  logic start;
  logic stop;
  logic out_ready;
  sample_buffer_pkg::out_word_t out_data;
  logic out_valid;
  logic out_last;
  logic capturing;
  logic buffer_full;

  // reference model state
  logic [31:0] lfsr_state;
  sample_buffer_pkg::bank_mode_t model_mode;
  logic [sample_buffer_pkg::sample_width-1:0] stored [sample_buffer_pkg::channels][max_words];
  int stored_count [sample_buffer_pkg::channels];
  logic model_full;
  sample_buffer_pkg::out_word_t expected_q [$];
  int value_errors;
  int other_errors;

  tb_clock clock_gen (
    .clk (clk)
  );

  sample_buffer UUT (
    .clk          (clk),
    .reset        (reset),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .banking_mode (banking_mode),
    .config_valid (config_valid),
    .start        (start),
    .stop         (stop),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_last     (out_last),
    .capturing    (capturing),
    .buffer_full  (buffer_full)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic random_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [15:0] random_word();
    logic [15:0] w;
    for (int i = 0; i < 16; i++) begin
      w[i] = random_bit();
    end
    return w;
  endfunction

  // sample cycles plus a generous readout allowance per row
  function automatic int watchdog_cycles();
    int total;
    total = 20;
    for (int r = 0; r < row_count; r++) begin
      total += int'(rows[r].cycles) + 400;
    end
    return total;
  endfunction

  task automatic report_mismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
    value_errors++;
    $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
  endtask

  task automatic start_capture(input row_t row);
    // the mode only changes when this row needs a new one
    if (row.mode != model_mode) begin
      @(posedge clk);
      banking_mode <= row.mode;
      config_valid <= 1'b1;
      model_mode = row.mode;
    end
    @(posedge clk);
    config_valid <= 1'b0;
    start <= 1'b1;
  endtask

  task automatic capture_samples(input row_t row);
    logic [sample_buffer_pkg::channels-1:0] valid;
    logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::sample_width-1:0] data;
    logic done;
    int active;
    int capacity;
    active = 1 << model_mode;
    capacity = max_words >> model_mode;
    done = 1'b0;
    model_full = 1'b0;
    for (int c = 0; c < sample_buffer_pkg::channels; c++) begin
      stored_count[c] = 0;
    end
    for (int i = 0; i < int'(row.cycles) && !done; i++) begin
      @(posedge clk);
      start <= 1'b0;
      for (int c = 0; c < sample_buffer_pkg::channels; c++) begin
        valid[c] = row.sparse ? random_bit() : 1'b1;
        data[c] = random_word();
        // inactive channels are driven too and must be ignored
        if (valid[c] && c < active) begin
          stored[c][stored_count[c]] = data[c];
          stored_count[c]++;
          if (stored_count[c] == capacity) begin
            model_full = 1'b1;
          end
        end
      end
      sample_valid <= valid;
      sample_data <= data;
      stop <= row.use_stop && (i == int'(row.cycles) - 1);
      done = model_full || (row.use_stop && (i == int'(row.cycles) - 1));
      // every sample cycle of the row lies inside the capture
      @(negedge clk);
      assert (capturing === 1'b1) else begin
        report_mismatch("capturing", 16'd1, 16'(capturing));
      end
    end
    @(posedge clk);
    sample_valid <= '0;
    stop <= 1'b0;
    // capture ends right after the stopping or filling cycle
    @(negedge clk);
    assert (capturing === 1'b0) else begin
      report_mismatch("capturing", 16'd0, 16'(capturing));
    end
  endtask

  task automatic build_expected();
    sample_buffer_pkg::out_word_t w;
    expected_q.delete();
    for (int ch = 0; ch < (1 << model_mode); ch++) begin
      w = '0;
      w.header.channel = sample_buffer_pkg::channel_width'(ch);
      w.header.count = sample_buffer_pkg::count_width'(stored_count[ch]);
      expected_q.push_back(w);
      for (int j = 0; j < stored_count[ch]; j++) begin
        w.sample = stored[ch][j];
        expected_q.push_back(w);
      end
    end
  endtask

  task automatic read_out(input row_t row);
    int idx;
    logic got_last;
    logic seen_valid;
    logic strobed;
    idx = 0;
    got_last = 1'b0;
    seen_valid = 1'b0;
    strobed = 1'b0;
    while (!got_last) begin
      @(posedge clk);
      out_ready <= row.toggle_ready ? random_bit() : 1'b1;
      config_valid <= 1'b0;
      start <= 1'b0;
      // a mode change and a start while the readout runs must have no effect
      if (seen_valid && !strobed) begin
        banking_mode <= (model_mode == sample_buffer_pkg::mode_4ch) ?
                        sample_buffer_pkg::mode_1ch :
                        sample_buffer_pkg::bank_mode_t'(model_mode + 2'd1);
        config_valid <= 1'b1;
        start <= 1'b1;
        strobed = 1'b1;
      end
      @(negedge clk);
      seen_valid = seen_valid || out_valid;
      if (out_valid && out_ready) begin
        if (idx < expected_q.size()) begin
          assert (out_data === expected_q[idx]) else begin
            report_mismatch("out_data", expected_q[idx], out_data);
          end
          assert (out_last === (idx == expected_q.size() - 1)) else begin
            report_mismatch("out_last", 16'(idx == expected_q.size() - 1), 16'(out_last));
          end
        end else begin
          other_errors++;
          $display("readout sent more words than the model expects");
        end
        idx++;
        got_last = out_last;
      end
    end
    assert (idx == expected_q.size()) else begin
      other_errors++;
      $display("readout ended after %0d of %0d words", idx, expected_q.size());
    end
    assert (buffer_full === model_full) else begin
      report_mismatch("buffer_full", 16'(model_full), 16'(buffer_full));
    end
    @(posedge clk);
    out_ready <= 1'b0;
  endtask

  initial begin
    lfsr_state = 32'hff6;
    value_errors = 0;
    other_errors = 0;
    model_mode = sample_buffer_pkg::mode_1ch;
    reset = 1'b1;
    sample_data = '0;
    sample_valid = '0;
    banking_mode = sample_buffer_pkg::mode_1ch;
    config_valid = 1'b0;
    start = 1'b0;
    stop = 1'b0;
    out_ready = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    for (int r = 0; r < row_count; r++) begin
      start_capture(rows[r]);
      capture_samples(rows[r]);
      build_expected();
      read_out(rows[r]);
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles()) @(posedge clk);
    $display("watchdog: run did not finish within %0d clock cycles", watchdog_cycles());
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/sample_buffer_assert.sv */
// checks the output stream handshake and capture/readout exclusion; all checks are off during reset
`default_nettype none

module sample_buffer_assert (
  input logic clk,
  input logic reset,
  input logic [sample_buffer_pkg::sample_width-1:0] out_data,
  input logic out_valid,
  input logic out_ready,
  input logic out_last,
  input logic capturing
);

  timeunit 1ns;
  timeprecision 100ps;

  // a stalled word stays on the bus unchanged until it is taken
  hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
    else $error("output word changed while out_ready was low");

  last_needs_valid: assert property (@(posedge clk) disable iff (reset)
    out_last |-> out_valid)
    else $error("out_last high without out_valid");

  no_overlap: assert property (@(posedge clk) disable iff (reset)
    !(capturing && out_valid))
    else $error("capturing and out_valid high together");

endmodule

bind sample_buffer sample_buffer_assert protocol_checks (
  .clk       (clk),
  .reset     (reset),
  .out_data  (out_data),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_last  (out_last),
  .capturing (capturing)
);

`default_nettype wire

/* verification/tb_clock.sv */
// free-running clock that starts low; the first rising edge comes at 50 ns
`default_nettype none

module tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

endmodule

`default_nettype wire

/* hw/sample_buffer.sv */
// capture runs until stop or the first full channel; readout needs out_ready and blocks new captures
`default_nettype none

module sample_buffer (
  input  logic clk,
  input  logic reset,
  input  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::sample_width-1:0] sample_data,
  input  logic [sample_buffer_pkg::channels-1:0] sample_valid,
  input  sample_buffer_pkg::bank_mode_t banking_mode,
  input  logic config_valid,
  input  logic start,
  input  logic stop,
  output sample_buffer_pkg::out_word_t out_data,
  output logic out_valid,
  input  logic out_ready,
  output logic out_last,
  output logic capturing,
  output logic buffer_full
);

  logic [sample_buffer_pkg::banks-1:0] wr_en;
  logic [sample_buffer_pkg::banks-1:0][sample_buffer_pkg::bank_addr_width-1:0] wr_addr;
  logic [sample_buffer_pkg::banks-1:0][sample_buffer_pkg::sample_width-1:0] wr_data;
  logic capture_done;
  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::count_width-1:0] channel_count;
  sample_buffer_pkg::bank_mode_t active_mode;
  logic readout_busy;
  logic [sample_buffer_pkg::channel_width-1:0] rd_bank;
  logic [sample_buffer_pkg::bank_addr_width-1:0] rd_addr;
  logic [sample_buffer_pkg::sample_width-1:0] rd_data;

  capture_writer writer (
    .clk           (clk),
    .reset         (reset),
    .sample_data   (sample_data),
    .sample_valid  (sample_valid),
    .banking_mode  (banking_mode),
    .config_valid  (config_valid),
    .start         (start),
    .stop          (stop),
    .readout_busy  (readout_busy),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .capture_done  (capture_done),
    .channel_count (channel_count),
    .active_mode   (active_mode),
    .capturing     (capturing),
    .buffer_full   (buffer_full)
  );

  bank_memory memory (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_bank (rd_bank),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  readout_serializer serializer (
    .clk           (clk),
    .reset         (reset),
    .capture_done  (capture_done),
    .channel_count (channel_count),
    .active_mode   (active_mode),
    .rd_data       (rd_data),
    .out_ready     (out_ready),
    .rd_bank       (rd_bank),
    .rd_addr       (rd_addr),
    .out_data      (out_data),
    .out_valid     (out_valid),
    .out_last      (out_last),
    .readout_busy  (readout_busy)
  );

endmodule

`default_nettype wire

/* hw/readout_serializer.sv */
// memory must not be written during readout; output is held stable while out_ready is low
`default_nettype none

module readout_serializer (
  input  logic clk,
  input  logic reset,
  input  logic capture_done,
  input  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::count_width-1:0] channel_count,
  input  sample_buffer_pkg::bank_mode_t active_mode,
  input  logic [sample_buffer_pkg::sample_width-1:0] rd_data,
  input  logic out_ready,
  output logic [sample_buffer_pkg::channel_width-1:0] rd_bank,
  output logic [sample_buffer_pkg::bank_addr_width-1:0] rd_addr,
  output sample_buffer_pkg::out_word_t out_data,
  output logic out_valid,
  output logic out_last,
  output logic readout_busy
);

  // current item pointer: channel, sample index and header flag
  logic fetch_active;
  logic in_header;
  logic [sample_buffer_pkg::channel_width-1:0] cur_ch;
  logic [sample_buffer_pkg::count_width-1:0] cur_idx;
  logic [sample_buffer_pkg::count_width-1:0] cur_count;

  logic nxt_active;
  logic nxt_header;
  logic [sample_buffer_pkg::channel_width-1:0] nxt_ch;
  logic [sample_buffer_pkg::count_width-1:0] nxt_idx;
  logic [sample_buffer_pkg::channel_width-1:0] rd_ch;
  logic [sample_buffer_pkg::count_width-1:0] rd_idx;

  logic at_last_ch;
  logic chan_end;
  logic load;
  logic item_last;
  sample_buffer_pkg::out_word_t item_word;

  assign cur_count = channel_count[cur_ch];
  assign at_last_ch = (cur_ch == sample_buffer_pkg::last_channel(active_mode));
  assign chan_end = (cur_idx == cur_count - 1'b1);
  assign load = fetch_active && (!out_valid || out_ready);
  assign readout_busy = fetch_active || out_valid;

  always_comb begin
    nxt_active = 1'b1;
    nxt_header = in_header;
    nxt_ch = cur_ch;
    nxt_idx = cur_idx;
    if (in_header) begin
      item_word.header.reserved = '0;
      item_word.header.channel = cur_ch;
      item_word.header.count = cur_count;
      item_last = at_last_ch && (cur_count == '0);
      if (cur_count != '0) begin
        nxt_header = 1'b0;
        nxt_idx = '0;
      end else if (at_last_ch) begin
        nxt_active = 1'b0;
      end else begin
        nxt_ch = cur_ch + 1'b1;
      end
    end else begin
      item_word.sample = rd_data;
      item_last = at_last_ch && chan_end;
      if (!chan_end) begin
        nxt_idx = cur_idx + 1'b1;
      end else if (at_last_ch) begin
        nxt_active = 1'b0;
      end else begin
        nxt_ch = cur_ch + 1'b1;
        nxt_header = 1'b1;
      end
    end
    // address the item that will be current next cycle so rd_data always matches it
    rd_ch = load ? nxt_ch : cur_ch;
    rd_idx = load ? nxt_idx : cur_idx;
  end

  assign rd_bank = sample_buffer_pkg::map_bank(active_mode, rd_ch, rd_idx);
  assign rd_addr = rd_idx[sample_buffer_pkg::bank_addr_width-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_active <= 1'b0;
      in_header <= 1'b1;
      cur_ch <= '0;
      cur_idx <= '0;
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end else begin
      if (capture_done) begin
        fetch_active <= 1'b1;
        in_header <= 1'b1;
        cur_ch <= '0;
        cur_idx <= '0;
      end else if (load) begin
        fetch_active <= nxt_active;
        in_header <= nxt_header;
        cur_ch <= nxt_ch;
        cur_idx <= nxt_idx;
      end
      if (load) begin
        out_valid <= 1'b1;
        out_last <= item_last;
      end else if (out_ready) begin
        out_valid <= 1'b0;
        out_last <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= item_word;
    end
  end

endmodule

`default_nettype wire

/* hw/bank_memory.sv */
// no reset on contents; read data is valid one cycle after rd_bank and rd_addr
`default_nettype none

module bank_memory (
  input  logic clk,
  input  logic [sample_buffer_pkg::banks-1:0] wr_en,
  input  logic [sample_buffer_pkg::banks-1:0][sample_buffer_pkg::bank_addr_width-1:0] wr_addr,
  input  logic [sample_buffer_pkg::banks-1:0][sample_buffer_pkg::sample_width-1:0] wr_data,
  input  logic [sample_buffer_pkg::channel_width-1:0] rd_bank,
  input  logic [sample_buffer_pkg::bank_addr_width-1:0] rd_addr,
  output logic [sample_buffer_pkg::sample_width-1:0] rd_data
);

  logic [sample_buffer_pkg::banks-1:0][sample_buffer_pkg::sample_width-1:0] bank_q;
  logic [sample_buffer_pkg::channel_width-1:0] bank_sel_q;

  // each bank is its own array with a registered read
  for (genvar b = 0; b < sample_buffer_pkg::banks; b++) begin : g_bank
    logic [sample_buffer_pkg::sample_width-1:0] words [sample_buffer_pkg::bank_depth];

    always_ff @(posedge clk) begin
      if (wr_en[b]) begin
        words[wr_addr[b]] <= wr_data[b];
      end
      bank_q[b] <= words[rd_addr];
    end
  end

  // bank select follows the address by one cycle to line up with bank_q
  always_ff @(posedge clk) begin
    bank_sel_q <= rd_bank;
  end

  assign rd_data = bank_q[bank_sel_q];

endmodule

`default_nettype wire

/* hw/capture_writer.sv */
// samples are single-cycle strobes with no back-pressure; mode and start only act while idle
`default_nettype none

module capture_writer (
  input  logic clk,
  input  logic reset,
  input  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::sample_width-1:0] sample_data,
  input  logic [sample_buffer_pkg::channels-1:0] sample_valid,
  input  sample_buffer_pkg::bank_mode_t banking_mode,
  input  logic config_valid,
  input  logic start,
  input  logic stop,
  input  logic readout_busy,
  output logic [sample_buffer_pkg::banks-1:0] wr_en,
  output logic [sample_buffer_pkg::banks-1:0][sample_buffer_pkg::bank_addr_width-1:0] wr_addr,
  output logic [sample_buffer_pkg::banks-1:0][sample_buffer_pkg::sample_width-1:0] wr_data,
  output logic capture_done,
  output logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::count_width-1:0] channel_count,
  output sample_buffer_pkg::bank_mode_t active_mode,
  output logic capturing,
  output logic buffer_full
);

  logic idle;
  logic fill_now;
  logic full_q;
  logic [sample_buffer_pkg::channels-1:0] store;
  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::count_width-1:0] count_inc;
  logic [sample_buffer_pkg::count_width-1:0] capacity;
  logic [sample_buffer_pkg::channel_width-1:0] last_ch;

  // capture_done covers the one cycle between capture end and readout start
  assign idle = !capturing && !capture_done && !readout_busy;
  assign capacity = sample_buffer_pkg::count_width'(sample_buffer_pkg::banks *
                    sample_buffer_pkg::bank_depth) >> active_mode;
  assign last_ch = sample_buffer_pkg::last_channel(active_mode);
  assign buffer_full = full_q || fill_now;

  // route each storing channel to its bank; active channels never collide
  always_comb begin
    logic [sample_buffer_pkg::channel_width-1:0] bank;
    wr_en = '0;
    wr_addr = '0;
    wr_data = '0;
    fill_now = 1'b0;
    for (int c = 0; c < sample_buffer_pkg::channels; c++) begin
      store[c] = capturing && sample_valid[c] &&
                 (sample_buffer_pkg::channel_width'(c) <= last_ch);
      count_inc[c] = channel_count[c] + 1'b1;
      bank = sample_buffer_pkg::map_bank(active_mode,
                                         sample_buffer_pkg::channel_width'(c),
                                         channel_count[c]);
      if (store[c]) begin
        wr_en[bank] = 1'b1;
        wr_addr[bank] = channel_count[c][sample_buffer_pkg::bank_addr_width-1:0];
        wr_data[bank] = sample_data[c];
        if (count_inc[c] == capacity) begin
          fill_now = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      capturing <= 1'b0;
      capture_done <= 1'b0;
      full_q <= 1'b0;
      active_mode <= sample_buffer_pkg::mode_1ch;
      channel_count <= '0;
    end else begin
      capture_done <= capturing && (stop || fill_now);
      if (config_valid && idle) begin
        active_mode <= banking_mode;
      end
      if (start && idle) begin
        capturing <= 1'b1;
        full_q <= 1'b0;
        channel_count <= '0;
      end else if (capturing) begin
        for (int c = 0; c < sample_buffer_pkg::channels; c++) begin
          if (store[c]) begin
            channel_count[c] <= count_inc[c];
          end
        end
        // writes of the stopping or filling cycle are still kept
        if (stop || fill_now) begin
          capturing <= 1'b0;
        end
        if (fill_now) begin
          full_q <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/sample_buffer_pkg.sv */
// sizes are fixed here; banks must equal channels and a bank index shares the channel index width
`default_nettype none

package sample_buffer_pkg;

  localparam int sample_width = 16;
  localparam int channels = 4;
  localparam int banks = channels;
  localparam int bank_depth = 32;
  localparam int bank_addr_width = 5;
  // a single channel may own all 128 words, so the count needs 8 bits
  localparam int count_width = 8;
  localparam int channel_width = 2;

  // number of active channels is 1 << mode
  typedef enum logic [1:0] {
    mode_1ch = 2'd0,
    mode_2ch = 2'd1,
    mode_4ch = 2'd2
  } bank_mode_t;

  // one output word, either a stored sample or a channel header
  typedef union packed {
    logic [sample_width-1:0] sample;
    struct packed {
      logic [5:0] reserved;
      logic [channel_width-1:0] channel;
      logic [count_width-1:0] count;
    } header;
  } out_word_t;

  // highest active channel index for a mode
  function automatic logic [channel_width-1:0] last_channel(input bank_mode_t mode);
    return channel_width'((1 << mode) - 1);
  endfunction

  // channel ch owns banks ch*k .. ch*k+k-1 with k = 4 >> mode
  function automatic logic [channel_width-1:0] map_bank(
    input bank_mode_t mode,
    input logic [channel_width-1:0] ch,
    input logic [count_width-1:0] n
  );
    logic [channel_width-1:0] base;
    base = ch << (2'd2 - mode);
    return base + n[bank_addr_width +: channel_width];
  endfunction

endpackage

`default_nettype wire
